// ==== hw/mk14_consts.svh ====
// memory map and timing constants of the MK14 memory side, included by the RTL and testbench
`ifndef MK14_CONSTS_SVH
`define MK14_CONSTS_SVH

// page nibbles, bits 11:8 of the address
`define MK14_STD_PAGE 4'hF
`define MK14_EXT_PAGE 4'hB
`define MK14_DISP_PAGE0 4'h9
`define MK14_DISP_PAGE1 4'hD

// LED latch, full address in the upper display page
`define MK14_LED_ADDR 16'h0D08

// bytes in each of the standard and extension RAMs
`define MK14_RAM_DEPTH 256

// clock cycles per scan slot
`define MK14_SCAN_DIV 16

// seven-segment digits on the board
`define MK14_DIGITS 8

`endif

// ==== hw/mk14_pkg.sv ====
// shared address, bus and display types, imported by the RTL and the testbench
`default_nettype none

`include "mk14_consts.svh"

package mk14_pkg;

	// address split into the fields the page decoder looks at
	typedef struct packed {
		logic [3:0] upper;
		logic [3:0] page;
		logic [7:0] offset;
	} mk14_addr_s;

	// same 16-bit word, raw or decoded
	typedef union packed {
		logic [15:0] word;
		mk14_addr_s f;
	} mk14_addr_u;

	// what the host holds stable during a handshake
	typedef struct packed {
		mk14_addr_u addr;
		logic we;
		logic [7:0] wdata;
	} host_req_t;

	// single-cycle access from the bridge into the memory unit
	typedef struct packed {
		logic valid;
		mk14_addr_u addr;
		logic we;
		logic [7:0] wdata;
	} core_bus_t;

	typedef struct packed {
		logic [7:0] seg;
		logic [`MK14_DIGITS-1:0] dig; // one-hot, zero when nothing shown yet
		logic [7:0] led;
	} disp_out_t;

endpackage

`default_nettype wire

// ==== hw/sdp_ram.sv ====
// simple dual-port RAM with registered read, instantiated for the standard and extension RAMs
`default_nettype none

module sdp_ram #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 256
) (
	input wire logic clk,
	input wire logic we,
	input wire logic [$clog2(DEPTH)-1:0] waddr,
	input wire logic [$clog2(DEPTH)-1:0] raddr,
	input wire logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr]; // old data on a same-address write
	end

endmodule

`default_nettype wire

// ==== hw/host_bridge.sv ====
// four-phase req/ack host port, turns each handshake into one core access and returns the read byte
`default_nettype none

module host_bridge (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire mk14_pkg::host_req_t host_req,
	output logic ack,
	output logic [7:0] rdata,
	output mk14_pkg::core_bus_t core,
	input wire logic [7:0] core_rdata
);

	import mk14_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_ACCESS,
		ST_CAPTURE,
		ST_HOLD
	} state_t;

	state_t state;
	logic core_valid;
	host_req_t pl_q; // request as sampled at the first req edge

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			core_valid <= 1'b0;
			ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req && !ack) begin
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					core_valid <= 1'b1;
					state <= ST_ACCESS;
				end
				ST_ACCESS: begin
					core_valid <= 1'b0; // memory unit acts at this edge
					state <= ST_CAPTURE;
				end
				ST_CAPTURE: begin
					ack <= 1'b1;
					state <= ST_HOLD;
				end
				ST_HOLD: begin
					if (!req) begin // host has seen ack
						ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req) begin
			pl_q <= host_req;
		end
		if (state == ST_CAPTURE) begin
			rdata <= core_rdata;
		end
	end

	always_comb begin
		core.valid = core_valid;
		core.addr = pl_q.addr;
		core.we = pl_q.we;
		core.wdata = pl_q.wdata;
	end

endmodule

`default_nettype wire

// ==== hw/mk14_mmu.sv ====
// memory unit: page decode, both RAMs, display digits with auto-dim, LED latch and keyboard rows
`default_nettype none

`include "mk14_consts.svh"

module mk14_mmu (
	input wire logic clk,
	input wire logic rst,
	input wire mk14_pkg::core_bus_t core,
	output logic [7:0] core_rdata,
	input wire logic disp_rd_en,
	input wire mk14_pkg::mk14_addr_u disp_addr,
	output logic [7:0] disp_rdata,
	input wire logic kbd_en,
	input wire logic [2:0] kbd_row,
	input wire logic [2:0] kbd_bit,
	input wire logic kbd_pressed
);

	import mk14_pkg::*;

	localparam logic [1:0] SEL_ZERO = 2'd0;
	localparam logic [1:0] SEL_STD = 2'd1;
	localparam logic [1:0] SEL_EXT = 2'd2;
	localparam logic [1:0] SEL_KBD = 2'd3;

	logic std_sel;
	logic ext_sel;
	logic disp_sel;
	logic led_hit;
	logic digit_hit;
	logic wr;
	logic [2:0] idx; // digit or keyboard row

	logic [7:0] std_rdata;
	logic [7:0] ext_rdata;
	logic [1:0] rd_sel;
	logic [7:0] kbd_q;

	logic [7:0] digits [`MK14_DIGITS];
	logic [`MK14_DIGITS-1:0] shown;
	logic [7:0] leds;
	logic [7:0] kbd_rows [8];

	logic disp_led;
	logic disp_digit;
	logic [2:0] disp_idx;

	// the upper nibble is ignored, as on the board
	assign std_sel = core.addr.f.page == `MK14_STD_PAGE;
	assign ext_sel = core.addr.f.page == `MK14_EXT_PAGE;
	assign disp_sel = core.addr.f.page == `MK14_DISP_PAGE0 ||
		core.addr.f.page == `MK14_DISP_PAGE1;
	assign led_hit = core.addr.word == `MK14_LED_ADDR;
	assign digit_hit = core.addr.f.offset < `MK14_DIGITS;
	assign idx = core.addr.f.offset[2:0];
	assign wr = core.valid && core.we;

	sdp_ram #(
		.WIDTH(8),
		.DEPTH(`MK14_RAM_DEPTH)
	) std_ram (
		.clk(clk),
		.we(wr && std_sel),
		.waddr(core.addr.f.offset),
		.raddr(core.addr.f.offset),
		.wdata(core.wdata),
		.rdata(std_rdata)
	);

	sdp_ram #(
		.WIDTH(8),
		.DEPTH(`MK14_RAM_DEPTH)
	) ext_ram (
		.clk(clk),
		.we(wr && ext_sel),
		.waddr(core.addr.f.offset),
		.raddr(core.addr.f.offset),
		.wdata(core.wdata),
		.rdata(ext_rdata)
	);

	// core read source, picked at the access edge
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_sel <= SEL_ZERO;
		end else if (core.valid && !core.we) begin
			if (std_sel) begin
				rd_sel <= SEL_STD;
			end else if (ext_sel) begin
				rd_sel <= SEL_EXT;
			end else if (disp_sel && digit_hit) begin
				rd_sel <= SEL_KBD;
			end else begin
				rd_sel <= SEL_ZERO; // unmapped, LED included
			end
		end
	end

	always_ff @(posedge clk) begin
		if (core.valid && !core.we) begin
			kbd_q <= kbd_rows[idx];
		end
	end

	always_comb begin
		case (rd_sel)
			SEL_STD: core_rdata = std_rdata;
			SEL_EXT: core_rdata = ext_rdata;
			SEL_KBD: core_rdata = kbd_q;
			default: core_rdata = 8'h00;
		endcase
	end

	assign disp_led = disp_addr.word == `MK14_LED_ADDR;
	assign disp_digit = disp_addr.f.offset < `MK14_DIGITS;
	assign disp_idx = disp_addr.f.offset[2:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			shown <= '0;
			leds <= 8'h00;
		end else begin
			if (disp_rd_en && !disp_led && disp_digit) begin
				shown[disp_idx] <= 1'b0; // dims after one read
			end
			if (wr && disp_sel) begin
				if (led_hit) begin
					leds <= core.wdata;
				end else if (digit_hit) begin
					shown[idx] <= 1'b1; // a write at the same edge wins
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr && disp_sel && !led_hit && digit_hit) begin
			digits[idx] <= core.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_rd_en) begin
			if (disp_led) begin
				disp_rdata <= leds;
			end else if (disp_digit && shown[disp_idx]) begin
				disp_rdata <= digits[disp_idx];
			end else begin
				disp_rdata <= 8'h00;
			end
		end
	end

	// rows are active low, a press pulls the bit down
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				kbd_rows[i] <= 8'hFF;
			end
		end else if (kbd_en) begin
			kbd_rows[kbd_row][kbd_bit] <= !kbd_pressed;
		end
	end

endmodule

`default_nettype wire

// ==== hw/display_scanner.sv ====
// walks the eight digits and the LED byte through the display read port and drives the outputs
`default_nettype none

`include "mk14_consts.svh"

module display_scanner (
	input wire logic clk,
	input wire logic rst,
	input wire logic scan_en,
	output logic disp_rd_en,
	output mk14_pkg::mk14_addr_u disp_addr,
	input wire logic [7:0] disp_rdata,
	output mk14_pkg::disp_out_t disp
);

	import mk14_pkg::*;

	localparam int SLOTS = `MK14_DIGITS + 1; // last slot is the LED byte
	localparam int SLOT_W = $clog2(SLOTS);
	localparam int DIV_W = $clog2(`MK14_SCAN_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic [SLOT_W-1:0] slot;
	logic [SLOT_W-1:0] rd_slot;
	logic rd_q; // read data arrives this cycle

	always_ff @(posedge clk) begin
		if (rst || !scan_en) begin
			div_cnt <= '0;
			slot <= '0;
		end else if (div_cnt == DIV_W'(`MK14_SCAN_DIV - 1)) begin
			div_cnt <= '0;
			slot <= (slot == SLOT_W'(SLOTS - 1)) ? '0 : slot + 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign disp_rd_en = scan_en && div_cnt == '0;

	always_comb begin
		disp_addr.f.upper = 4'h0;
		disp_addr.f.page = `MK14_DISP_PAGE1;
		disp_addr.f.offset = 8'(slot); // slot 8 lands on the LED latch
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= disp_rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_rd_en) begin
			rd_slot <= slot;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			disp <= '0;
		end else if (rd_q) begin
			if (rd_slot == SLOT_W'(`MK14_DIGITS)) begin
				disp.led <= disp_rdata; // digit select holds
			end else begin
				disp.seg <= disp_rdata;
				disp.dig <= `MK14_DIGITS'(1) << rd_slot;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/mk14_mem_top.sv ====
// top of the MK14 memory side, host bridge plus memory unit plus display scanner
`default_nettype none

module mk14_mem_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire mk14_pkg::host_req_t host_req,
	output logic ack,
	output logic [7:0] rdata,
	input wire logic scan_en,
	input wire logic kbd_en,
	input wire logic [2:0] kbd_row,
	input wire logic [2:0] kbd_bit,
	input wire logic kbd_pressed,
	output mk14_pkg::disp_out_t disp
);

	import mk14_pkg::*;

	core_bus_t core;
	logic [7:0] core_rdata;
	logic disp_rd_en;
	mk14_addr_u disp_addr;
	logic [7:0] disp_rdata;

	host_bridge u_bridge (
		.clk(clk),
		.rst(rst),
		.req(req),
		.host_req(host_req),
		.ack(ack),
		.rdata(rdata),
		.core(core),
		.core_rdata(core_rdata)
	);

	mk14_mmu u_mmu (
		.clk(clk),
		.rst(rst),
		.core(core),
		.core_rdata(core_rdata),
		.disp_rd_en(disp_rd_en),
		.disp_addr(disp_addr),
		.disp_rdata(disp_rdata),
		.kbd_en(kbd_en),
		.kbd_row(kbd_row),
		.kbd_bit(kbd_bit),
		.kbd_pressed(kbd_pressed)
	);

	display_scanner u_scanner (
		.clk(clk),
		.rst(rst),
		.scan_en(scan_en),
		.disp_rd_en(disp_rd_en),
		.disp_addr(disp_addr),
		.disp_rdata(disp_rdata),
		.disp(disp)
	);

endmodule

`default_nettype wire

// ==== sim/mk14_mem_asserts.sv ====
// concurrent checks on the host handshake and the scanner digit select, bound into the RTL
`default_nettype none

`include "mk14_consts.svh"

module mk14_mem_asserts (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire logic ack,
	input wire logic valid,
	input wire logic [`MK14_DIGITS-1:0] dig
);

	timeunit 1ns;
	timeprecision 1ps;

	// ack may only come up while the host is still requesting
	ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
		(ack && !$past(ack)) |-> $past(req))
		else $error("ack rose while req was low");

	ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
		(!ack && $past(ack)) |-> !$past(req))
		else $error("ack fell while req was still high");

	valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
		valid |=> !valid)
		else $error("core valid held for more than one cycle");

	dig_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(dig))
		else $error("digit select is not one-hot");

endmodule

bind host_bridge mk14_mem_asserts u_bridge_chk (
	.clk(clk),
	.rst(rst),
	.req(req),
	.ack(ack),
	.valid(core.valid),
	.dig('0)
);

// scanner side only has the digit select to watch
bind display_scanner mk14_mem_asserts u_scanner_chk (
	.clk(clk),
	.rst(rst),
	.req(1'b0),
	.ack(1'b0),
	.valid(1'b0),
	.dig(disp.dig)
);

`default_nettype wire

// ==== sim/tb_mk14_mem.sv ====
// testbench for the MK14 memory side, runs RAM, keyboard, display and handshake tests
`default_nettype none

`include "mk14_consts.svh"

module tb_mk14_mem;

	timeunit 1ns;
	timeprecision 1ps;

	import mk14_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic rst;
	logic req;
	host_req_t host_req;
	logic ack;
	logic [7:0] rdata;
	logic scan_en;
	logic kbd_en;
	logic [2:0] kbd_row;
	logic [2:0] kbd_bit;
	logic kbd_pressed;
	disp_out_t disp;

	// shadow state of the memory unit
	logic [7:0] std_sh [`MK14_RAM_DEPTH];
	logic [7:0] ext_sh [`MK14_RAM_DEPTH];
	logic [7:0] dig_sh [`MK14_DIGITS];
	logic shown_sh [`MK14_DIGITS];
	logic [7:0] led_sh;
	logic [7:0] kbd_sh [8];

	logic [15:0] lfsr = 16'd33;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int handshakes = 0;
	int timing_errs = 0;

	// read compare, filled in by host_read and consumed by the compare process
	logic rd_pending = 1'b0;
	logic [7:0] rd_exp;
	string rd_name;
	logic ack_prev = 1'b0;

	mk14_mem_top u_dut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.host_req(host_req),
		.ack(ack),
		.rdata(rdata),
		.scan_en(scan_en),
		.kbd_en(kbd_en),
		.kbd_row(kbd_row),
		.kbd_bit(kbd_bit),
		.kbd_pressed(kbd_pressed),
		.disp(disp)
	);

	always #20 clk = !clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// expected host read byte from the memory map
	function automatic logic [7:0] ref_read(mk14_addr_u a);
		if (a.f.page == `MK14_STD_PAGE)
			return std_sh[a.f.offset];
		if (a.f.page == `MK14_EXT_PAGE)
			return ext_sh[a.f.offset];
		if ((a.f.page == `MK14_DISP_PAGE0 || a.f.page == `MK14_DISP_PAGE1) && a.f.offset < 8)
			return kbd_sh[a.f.offset[2:0]];
		return 8'h00; // unmapped, LED too
	endfunction

	function automatic void ref_write(mk14_addr_u a, logic [7:0] d);
		if (a.f.page == `MK14_STD_PAGE) begin
			std_sh[a.f.offset] = d;
		end else if (a.f.page == `MK14_EXT_PAGE) begin
			ext_sh[a.f.offset] = d;
		end else if (a.f.page == `MK14_DISP_PAGE0 || a.f.page == `MK14_DISP_PAGE1) begin
			if (a.word == `MK14_LED_ADDR) begin
				led_sh = d;
			end else if (a.f.offset < `MK14_DIGITS) begin
				dig_sh[a.f.offset[2:0]] = d;
				shown_sh[a.f.offset[2:0]] = 1'b1;
			end
		end
	endfunction

	// display outputs after one scan slot, a digit dims once shown
	function automatic disp_out_t ref_scan(int slot, disp_out_t prev);
		disp_out_t e;
		e = prev;
		if (slot < `MK14_DIGITS) begin
			e.seg = shown_sh[slot] ? dig_sh[slot] : 8'h00;
			shown_sh[slot] = 1'b0;
			e.dig = `MK14_DIGITS'(1) << slot;
		end else begin
			e.led = led_sh;
		end
		return e;
	endfunction

	task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %02h actual %02h", name, exp, act);
		end
	endtask

	task automatic check_disp(string name, disp_out_t exp, disp_out_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected seg %02h dig %02h led %02h actual seg %02h dig %02h led %02h",
				name, exp.seg, exp.dig, exp.led, act.seg, act.dig, act.led);
		end
	endtask

	// compares read data when ack comes up
	always @(negedge clk) begin
		if (ack && !ack_prev && rd_pending) begin
			check_byte(rd_name, rd_exp, rdata);
			rd_pending = 1'b0;
		end
		ack_prev = ack;
	end

	task automatic host_access(host_req_t r);
		int n;
		@(posedge clk);
		host_req <= r;
		req <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			@(negedge clk);
		end while (!ack);
		handshakes++;
		checks++;
		if (n != 4) begin // 3 cycles after the first edge that sees req
			errors++;
			timing_errs++;
			$display("handshake to %04h: ack rose %0d cycles after req was seen, not 3",
				r.addr.word, n - 1);
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		if (!ack) begin
			errors++;
			timing_errs++;
			$display("handshake to %04h: ack dropped before req went low", r.addr.word);
		end
		@(posedge clk);
		@(negedge clk);
		if (ack) begin
			errors++;
			timing_errs++;
			$display("handshake to %04h: ack still high a cycle after req dropped",
				r.addr.word);
		end
	endtask

	task automatic host_write(logic [15:0] addr, logic [7:0] d);
		host_req_t r;
		r.addr.word = addr;
		r.we = 1'b1;
		r.wdata = d;
		ref_write(r.addr, d);
		host_access(r);
	endtask

	task automatic host_read(string name, logic [15:0] addr);
		host_req_t r;
		r.addr.word = addr;
		r.we = 1'b0;
		r.wdata = 8'(take_bits(8));
		rd_exp = ref_read(r.addr);
		rd_name = $sformatf("%s %04h", name, addr);
		rd_pending = 1'b1;
		host_access(r);
		if (rd_pending) begin
			errors++;
			rd_pending = 1'b0;
			$display("read of %04h finished without a compare", addr);
		end
	endtask

	task automatic end_test(string name, int errs_before);
		$display("test %-12s errors %0d", name, errors - errs_before);
	endtask

	initial begin
		logic [7:0] offs [24];
		logic [15:0] a;
		logic [7:0] d;
		int e0;
		disp_out_t exp_d;
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		host_req = '0;
		scan_en = 1'b0;
		kbd_en = 1'b0;
		kbd_row = 3'd0;
		kbd_bit = 3'd0;
		kbd_pressed = 1'b0;
		for (int i = 0; i < 8; i++) begin
			kbd_sh[i] = 8'hFF;
			shown_sh[i] = 1'b0;
			dig_sh[i] = 8'h00;
		end
		led_sh = 8'h00;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		e0 = errors;
		for (int i = 0; i < 24; i++) begin
			offs[i] = 8'(take_bits(8));
			d = 8'(take_bits(8));
			host_write({4'(take_bits(4)), `MK14_STD_PAGE, offs[i]}, d);
			host_write({4'h0, `MK14_EXT_PAGE, offs[i]}, d ^ 8'h5A); // differs from std
		end
		for (int i = 0; i < 24; i++) begin
			host_read("std_ram", {4'h0, `MK14_STD_PAGE, offs[i]});
			host_read("ext_ram", {4'(take_bits(4)), `MK14_EXT_PAGE, offs[i]});
		end
		end_test("ram_access", e0);

		e0 = errors;
		host_read("unmapped", 16'h0000);
		host_read("unmapped", 16'h00FF);
		host_read("unmapped", 16'h0100);
		host_read("unmapped", 16'h01FF);
		host_read("unmapped", 16'h1200);
		host_read("led_core", `MK14_LED_ADDR);
		host_read("disp_off8", 16'h0908);
		for (int i = 0; i < 6; i++) begin
			a = 16'(take_bits(16));
			a[11:8] = 4'(take_bits(3)); // pages 0 to 7
			host_read("unmapped", a);
		end
		end_test("unmapped", e0);

		e0 = errors;
		for (int i = 0; i < 40; i++) begin
			@(posedge clk);
			kbd_en <= 1'b1;
			kbd_row <= 3'(take_bits(3));
			kbd_bit <= 3'(take_bits(3));
			kbd_pressed <= take_bits(1) != 0;
			@(posedge clk);
			kbd_en <= 1'b0;
			kbd_sh[kbd_row][kbd_bit] = !kbd_pressed;
		end
		for (int r = 0; r < 8; r++) begin
			host_read("kbd_row", 16'h0900 + 16'(r));
			host_read("kbd_row_hi", 16'h0D00 + 16'(r));
		end
		end_test("keyboard", e0);

		e0 = errors;
		for (int i = 0; i < `MK14_DIGITS; i++) begin
			d = 8'(take_bits(8)) | 8'h01; // nonzero, so dimming shows
			host_write((i % 2 == 0 ? 16'h0D00 : 16'h0900) + 16'(i), d);
		end
		host_write(`MK14_LED_ADDR, 8'(take_bits(8)));
		@(negedge clk);
		exp_d = '0;
		check_disp("disp_idle", exp_d, disp);
		@(posedge clk);
		scan_en <= 1'b1;
		for (int s = 0; s < 2 * (`MK14_DIGITS + 1); s++) begin
			// sample mid-slot, well after the update two cycles in
			repeat (s == 0 ? 8 : `MK14_SCAN_DIV) @(posedge clk);
			@(negedge clk);
			exp_d = ref_scan(s % (`MK14_DIGITS + 1), exp_d);
			check_disp($sformatf("scan pass %0d slot %0d", s / 9, s % 9), exp_d, disp);
		end
		@(posedge clk);
		scan_en <= 1'b0;
		end_test("display", e0);

		$display("test %-12s errors %0d over %0d handshakes", "handshake", timing_errs,
			handshakes);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/mk14_pkg.sv
hw/sdp_ram.sv
hw/host_bridge.sv
hw/mk14_mmu.sv
hw/display_scanner.sv
hw/mk14_mem_top.sv
sim/mk14_mem_asserts.sv
sim/tb_mk14_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_mk14_mem \
	-Mdir obj_dir -o tb_mk14_mem

out=$(./obj_dir/tb_mk14_mem) || true
echo "$out"

echo "$out" | grep -qF '*** TEST PASSED ***'
